// File: mmioPkg.sv
// Shared register map, reset defaults and bus structs, imported by every MMIO client module
package mmioPkg;

  // Bus and memory geometry --------------------
  localparam int busAddrW  = 8;    // Host address bits
  localparam int busDataW  = 8;    // Host data bits
  localparam int pageBytes = 128;  // Upper window size
  localparam int xmemWordW = 32;   // Fabric word
  localparam int xmemAddrW = 9;    // Fabric word address, up to 16 pages

  // Register map, lower half only --------------
  // Config and build identification
  localparam logic [6:0] regEmifId   = 7'h00;
  localparam logic [6:0] regEmifVer  = 7'h01;
  localparam logic [6:0] regEmifRev  = 7'h02;
  localparam logic [6:0] regTopId    = 7'h04;
  localparam logic [6:0] regTopYear  = 7'h05;
  localparam logic [6:0] regTopMonth = 7'h06;
  localparam logic [6:0] regTopDay   = 7'h07;
  // Physical layer
  localparam logic [6:0] regPhyStat  = 7'h10;
  localparam logic [6:0] regPhyEth0  = 7'h11;  // 3 bytes, up to 0x13
  // Layer 2 and layer 3 addressing
  localparam logic [6:0] regMac      = 7'h22;  // 6 bytes
  localparam logic [6:0] regIp       = 7'h34;  // 4 bytes each
  localparam logic [6:0] regSubNet   = 7'h38;
  localparam logic [6:0] regGateway  = 7'h3C;
  // Diagnostics and paging
  localparam logic [6:0] regScratch  = 7'h70;  // 4 bytes
  localparam logic [6:0] regDiagCtrl = 7'h74;
  localparam logic [6:0] regPageSel  = 7'h7F;

  // Reset defaults -----------------------------
  // Multi-byte values hold the lowest register in bits 7:0
  localparam logic [7:0]  defEmifId  = 8'h3C;         // Variant with memory
  localparam logic [7:0]  defEmifVer = 8'h01;
  localparam logic [7:0]  defEmifRev = 8'h00;
  localparam logic [7:0]  defTopId   = 8'h81;
  localparam logic [23:0] defPhyEth0 = 24'h05_05_41;
  localparam logic [31:0] defSubNet  = 32'h00_00_FF_FF;  // 255.255.0.0
  localparam logic [31:0] defGateway = 32'h01_00_0C_0A;  // 10.12.0.1
  localparam logic [31:0] defScratch = 32'hEF_BE_AD_DE;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [busAddrW-1:0] adr;
    logic [busDataW-1:0] datW;
  } wbReqT;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic                ack;
    logic [busDataW-1:0] datR;
  } wbRspT;

  // Shell status, mc0CalDone lands in bit 0
  typedef struct packed {
    logic eth0QpllLock;
    logic eth0CoreReady;
    logic mc1CalDone;
    logic mc0CalDone;
  } shellStatT;

  // Transceiver tuning
  typedef struct packed {
    logic       rxEqMode;
    logic [3:0] txSwing;
    logic [4:0] txPreCursor;
    logic [4:0] txPostCursor;
  } phyTuneT;

  // Network addressing
  typedef struct packed {
    logic [47:0] macAddr;
    logic [31:0] ipAddr;
    logic [31:0] subNetMask;
    logic [31:0] gatewayAddr;
  } netCfgT;

  // Loopback and memory test controls
  typedef struct packed {
    logic       pcsLoopbackEn;
    logic       macLoopbackEn;
    logic       macAddrSwapEn;
    logic [1:0] memTestCtrl;
  } diagCtrlT;

  // Fabric port of the paged memory
  typedef struct packed {
    logic                 en;
    logic                 wren;
    logic [xmemAddrW-1:0] addr;
    logic [xmemWordW-1:0] wrData;
  } xmemReqT;

endpackage

// File: xmemDualPortRam.sv
// Paged dual-port memory behind the upper window, bytes for the host and words for the fabric
`timescale 1ns/1ns

module xmemDualPortRam
  import mmioPkg::*;
#(
  parameter int xmemPages = 16  // 128 bytes per page
) (
  input  logic                                  shlClk,
  // Port A, host bytes
  input  logic                                  ramEnA,
  input  logic                                  ramWeA,
  input  logic [$clog2(xmemPages*pageBytes)-1:0] ramAddrA,
  input  logic [busDataW-1:0]                   ramWrDataA,
  output logic [busDataW-1:0]                   ramRdDataA,
  // Port B, fabric words
  input  xmemReqT                               xmemReq,
  output logic [xmemWordW-1:0]                  xmemRdData
);

  localparam int ramAddrW  = $clog2(xmemPages*pageBytes);
  localparam int wordAddrW = ramAddrW - 2;           // Four lanes per word
  localparam int memWords  = xmemPages * pageBytes / 4;

  // Word wide storage, lane 0 in bits 7:0
  logic [xmemWordW-1:0] mem [memWords];

  logic [wordAddrW-1:0] wordA;
  logic [1:0]           laneA;
  logic [wordAddrW-1:0] wordB;

  // Address split --------------------
  assign wordA = ramAddrA[ramAddrW-1:2];
  assign laneA = ramAddrA[1:0];
  assign wordB = wordAddrW'(xmemReq.addr);  // Upper bits unused below 16 pages

  // Both ports share one clock, so one process serves them
  always_ff @(posedge shlClk)
  begin
    // Port A
    if (ramEnA)
    begin
      if (ramWeA)
        mem[wordA][8*laneA +: 8] <= ramWrDataA;  // Single lane write
      ramRdDataA <= mem[wordA][8*laneA +: 8];    // Old data on write
    end
    // Port B
    if (xmemReq.en)
    begin
      if (xmemReq.wren)
        mem[wordB] <= xmemReq.wrData;            // Whole word
      xmemRdData <= mem[wordB];
    end
  end

  // Same byte written by both ports in one cycle is left undefined

  // Fabric must stay inside the populated pages
  xmemAddrInRange : assert property (@(posedge shlClk)
    xmemReq.en |-> (int'(xmemReq.addr) < memWords));

endmodule

// File: mmioRegFile.sv
// Control and status register bank of the MMIO client, host decode and packing of shell controls
`timescale 1ns/1ns

module mmioRegFile
  import mmioPkg::*;
(
  input  logic                shlClk,
  input  logic                arstN,
  // Decoded host access
  input  logic                regWe,
  input  logic [6:0]          regAddr,
  input  logic [busDataW-1:0] regWrData,
  output logic [busDataW-1:0] regRdData,
  // Read-only sources
  input  logic [31:0]         timestamp,
  input  shellStatT           shellStat,
  // Controls
  output logic [7:0]          pageSel,
  output phyTuneT             phyTune,
  output netCfgT              netCfg,
  output diagCtrlT            diagCtrl
);

  // Writable storage, lowest register in bits 7:0
  logic [23:0] phyEth0Q;
  logic [47:0] macQ;
  logic [31:0] ipQ;
  logic [31:0] subNetQ;
  logic [31:0] gatewayQ;
  logic [31:0] scratchQ;
  logic [7:0]  diagQ;
  logic [7:0]  pageQ;

  // Address falls inside a group of n bytes
  function automatic logic hit(input logic [6:0] addr, input logic [6:0] base, input int n);
    return (addr >= base) && (int'(addr) < int'(base) + n);
  endfunction

  // Bit position of a byte inside its group
  function automatic int bitOfs(input logic [6:0] addr, input logic [6:0] base);
    return 8 * (int'(addr) - int'(base));
  endfunction

  // Host writes --------------------
  always_ff @(posedge shlClk or negedge arstN)
  begin
    if (!arstN)
    begin
      phyEth0Q <= defPhyEth0;
      macQ     <= '0;
      ipQ      <= '0;
      subNetQ  <= defSubNet;
      gatewayQ <= defGateway;
      scratchQ <= defScratch;
      diagQ    <= '0;
      pageQ    <= '0;
    end
    else if (regWe)
    begin
      case (regAddr)
        regDiagCtrl : diagQ <= regWrData;
        regPageSel  : pageQ <= regWrData;
        default :
        begin
          // Read-only and unmapped bytes fall through untouched
          if (hit(regAddr, regPhyEth0, 3))
            phyEth0Q[bitOfs(regAddr, regPhyEth0) +: 8] <= regWrData;
          if (hit(regAddr, regMac, 6))
            macQ[bitOfs(regAddr, regMac) +: 8] <= regWrData;
          if (hit(regAddr, regIp, 4))
            ipQ[bitOfs(regAddr, regIp) +: 8] <= regWrData;
          if (hit(regAddr, regSubNet, 4))
            subNetQ[bitOfs(regAddr, regSubNet) +: 8] <= regWrData;
          if (hit(regAddr, regGateway, 4))
            gatewayQ[bitOfs(regAddr, regGateway) +: 8] <= regWrData;
          if (hit(regAddr, regScratch, 4))
            scratchQ[bitOfs(regAddr, regScratch) +: 8] <= regWrData;
        end
      endcase
    end
  end

  // Read mux --------------------
  always_comb
  begin
    regRdData = '0;  // Unmapped reads as zero
    case (regAddr)
      regEmifId   : regRdData = defEmifId;
      regEmifVer  : regRdData = defEmifVer;
      regEmifRev  : regRdData = defEmifRev;
      regTopId    : regRdData = defTopId;
      regTopYear  : regRdData = {2'b00, timestamp[22:17]};   // Years since build epoch
      regTopMonth : regRdData = {4'h0, timestamp[26:23]};
      regTopDay   : regRdData = {3'b000, timestamp[31:27]};
      regPhyStat  : regRdData = {4'h0, shellStat};           // Live status, no storage
      regDiagCtrl : regRdData = diagQ;
      regPageSel  : regRdData = pageQ;
      default :
      begin
        if (hit(regAddr, regPhyEth0, 3))
          regRdData = phyEth0Q[bitOfs(regAddr, regPhyEth0) +: 8];
        else if (hit(regAddr, regMac, 6))
          regRdData = macQ[bitOfs(regAddr, regMac) +: 8];
        else if (hit(regAddr, regIp, 4))
          regRdData = ipQ[bitOfs(regAddr, regIp) +: 8];
        else if (hit(regAddr, regSubNet, 4))
          regRdData = subNetQ[bitOfs(regAddr, regSubNet) +: 8];
        else if (hit(regAddr, regGateway, 4))
          regRdData = gatewayQ[bitOfs(regAddr, regGateway) +: 8];
        else if (hit(regAddr, regScratch, 4))
          regRdData = scratchQ[bitOfs(regAddr, regScratch) +: 8];
      end
    endcase
  end

  // Control outputs --------------------
  assign pageSel = pageQ;

  assign phyTune = '{rxEqMode     : phyEth0Q[0],
                     txSwing      : phyEth0Q[7:4],
                     txPreCursor  : phyEth0Q[12:8],    // Second tuning byte
                     txPostCursor : phyEth0Q[20:16]};  // Third tuning byte

  assign netCfg = '{macAddr     : macQ,
                    ipAddr      : ipQ,
                    subNetMask  : subNetQ,
                    gatewayAddr : gatewayQ};

  // Bits 5:3 are kept for readback only
  assign diagCtrl = '{pcsLoopbackEn : diagQ[0],
                      macLoopbackEn : diagQ[1],
                      macAddrSwapEn : diagQ[2],
                      memTestCtrl   : diagQ[7:6]};

  // One write strobe per host access, the decoder rearms only after stb drops
  regWeSinglePulse : assert property (@(posedge shlClk) disable iff (!arstN)
    regWe |=> !regWe);

endmodule

// File: mmioBusDecode.sv
// Wishbone slave that splits host accesses between the register bank and the paged memory
`timescale 1ns/1ns

module mmioBusDecode
  import mmioPkg::*;
#(
  parameter int xmemPages = 16  // Pages behind the upper window
) (
  input  logic                                  shlClk,
  input  logic                                  arstN,
  // Host bus
  input  wbReqT                                 wbReq,
  output wbRspT                                 wbRsp,
  input  logic [7:0]                            pageSel,
  // Register bank
  output logic                                  regWe,
  output logic [6:0]                            regAddr,
  output logic [busDataW-1:0]                   regWrData,
  input  logic [busDataW-1:0]                   regRdData,
  // Memory port A
  output logic                                  ramEnA,
  output logic                                  ramWeA,
  output logic [$clog2(xmemPages*pageBytes)-1:0] ramAddrA,
  output logic [busDataW-1:0]                   ramWrDataA,
  input  logic [busDataW-1:0]                   ramRdDataA
);

  localparam int ramAddrW = $clog2(xmemPages*pageBytes);

  logic reqStart;  // First cycle of a new strobe
  logic busyQ;     // Access served, waiting for stb to drop
  logic ackQ;
  logic selRamQ;   // Bank of the access being acknowledged

  // Access tracking --------------------
  assign reqStart = wbReq.cyc & wbReq.stb & ~busyQ;

  always_ff @(posedge shlClk or negedge arstN)
  begin
    if (!arstN)
    begin
      busyQ   <= 1'b0;
      ackQ    <= 1'b0;
      selRamQ <= 1'b0;
    end
    else
    begin
      ackQ <= reqStart;  // Fixed one cycle latency
      if (!wbReq.stb)
        busyQ <= 1'b0;   // Rearm only after stb low
      else if (reqStart)
        busyQ <= 1'b1;
      if (reqStart)
        selRamQ <= wbReq.adr[7];
    end
  end

  // Lower half, register bank
  assign regWe     = reqStart & wbReq.we & ~wbReq.adr[7];  // Lands on the ack edge
  assign regAddr   = wbReq.adr[6:0];
  assign regWrData = wbReq.datW;

  // Upper half, page window
  assign ramEnA     = reqStart & wbReq.adr[7];
  assign ramWeA     = reqStart & wbReq.adr[7] & wbReq.we;
  assign ramAddrA   = ramAddrW'({pageSel, wbReq.adr[6:0]});  // Low page bits above offset
  assign ramWrDataA = wbReq.datW;

  // Register data follows the held address, memory data is already registered
  assign wbRsp.ack  = ackQ;
  assign wbRsp.datR = selRamQ ? ramRdDataA : regRdData;

  // Protocol checks --------------------
  ackSinglePulse : assert property (@(posedge shlClk) disable iff (!arstN)
    wbRsp.ack |=> !wbRsp.ack);

  ackInsideCycle : assert property (@(posedge shlClk) disable iff (!arstN)
    wbRsp.ack |-> wbReq.cyc);

endmodule

// File: mmioClient.sv
// Top of the MMIO client, joins the Wishbone decoder, the register bank and the paged memory
`timescale 1ns/1ns

module mmioClient
  import mmioPkg::*;
#(
  parameter int xmemPages = 16  // Power of two, 1 to 16
) (
  input  logic                 shlClk,
  input  logic                 arstN,
  // Host bus
  input  wbReqT                wbReq,
  output wbRspT                wbRsp,
  // Status sources
  input  logic [31:0]          timestamp,
  input  shellStatT            shellStat,
  // Shell controls
  output phyTuneT              phyTune,
  output netCfgT               netCfg,
  output diagCtrlT             diagCtrl,
  // Fabric memory port
  input  xmemReqT              xmemReq,
  output logic [xmemWordW-1:0] xmemRdData
);

  localparam int ramAddrW = $clog2(xmemPages*pageBytes);

  // Decoder to register bank
  logic                regWe;
  logic [6:0]          regAddr;
  logic [busDataW-1:0] regWrData;
  logic [busDataW-1:0] regRdData;
  logic [7:0]          pageSel;

  // Decoder to memory port A
  logic                ramEnA;
  logic                ramWeA;
  logic [ramAddrW-1:0] ramAddrA;
  logic [busDataW-1:0] ramWrDataA;
  logic [busDataW-1:0] ramRdDataA;

  // Bus decode --------------------
  mmioBusDecode #(
    .xmemPages (xmemPages)
  ) mmioBusDecode_inst (
    .shlClk     (shlClk),
    .arstN      (arstN),
    .wbReq      (wbReq),
    .wbRsp      (wbRsp),
    .pageSel    (pageSel),
    .regWe      (regWe),
    .regAddr    (regAddr),
    .regWrData  (regWrData),
    .regRdData  (regRdData),
    .ramEnA     (ramEnA),
    .ramWeA     (ramWeA),
    .ramAddrA   (ramAddrA),
    .ramWrDataA (ramWrDataA),
    .ramRdDataA (ramRdDataA)
  );

  // Register bank --------------------
  mmioRegFile mmioRegFile_inst (
    .shlClk    (shlClk),
    .arstN     (arstN),
    .regWe     (regWe),
    .regAddr   (regAddr),
    .regWrData (regWrData),
    .regRdData (regRdData),
    .timestamp (timestamp),
    .shellStat (shellStat),
    .pageSel   (pageSel),
    .phyTune   (phyTune),
    .netCfg    (netCfg),
    .diagCtrl  (diagCtrl)
  );

  // Paged memory --------------------
  xmemDualPortRam #(
    .xmemPages (xmemPages)
  ) xmemDualPortRam_inst (
    .shlClk     (shlClk),
    .ramEnA     (ramEnA),
    .ramWeA     (ramWeA),
    .ramAddrA   (ramAddrA),
    .ramWrDataA (ramWrDataA),
    .ramRdDataA (ramRdDataA),
    .xmemReq    (xmemReq),
    .xmemRdData (xmemRdData)
  );

endmodule

// File: mmioTbTasks.svh
// Testbench tasks for host and fabric transfers, idle gaps, the LFSR and value checks

// Mismatch report with time and message
task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string msg);
  if (got !== exp)
  begin
    $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
    errCount++;
  end
endtask

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// 0 to 3 idle cycles, two LFSR bits, ack must stay low
task automatic idleGap();
  int n;
  n = 0;
  for (int i = 0; i < 2; i++)
  begin
    lfsr = lfsrNext(lfsr);  // One step per bit
    n = 2 * n + int'(lfsr[0]);
  end
  repeat (n)
  begin
    @(negedge shlClk);
    checkEq(64'(wbRsp.ack), 64'd0, "ack outside an access");
  end
endtask

// Wishbone classic transfer, called right after a falling edge
task automatic wbAccess(input logic we, input logic [7:0] adr, input logic [7:0] datW,
                        output logic [7:0] datR);
  int waitCyc;
  waitCyc = 0;
  wbReq = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: datW};
  do
  begin
    @(negedge shlClk);
    waitCyc++;
  end while (!wbRsp.ack && waitCyc < 8);
  if (!wbRsp.ack)
  begin
    $display("Host access to address %h was never acknowledged", adr);
    errCount++;
  end
  checkEq(64'(waitCyc), 64'd1, "ack latency in cycles");
  datR      = wbRsp.datR;   // Valid while ack is high
  wbReq.stb = 1'b0;         // Strobe ends, cyc stays up through the ack edge
  @(negedge shlClk);
  checkEq(64'(wbRsp.ack), 64'd0, "ack longer than one cycle");
  wbReq = '0;
endtask

// Fabric word transfer, data one cycle after en
task automatic fabricAccess(input logic wren, input logic [8:0] addr, input logic [31:0] data,
                            output logic [31:0] rdData);
  xmemReq = '{en: 1'b1, wren: wren, addr: addr, wrData: data};
  @(negedge shlClk);
  xmemReq = '0;
  rdData  = xmemRdData;
endtask

// File: tbMmioClient.sv
// Testbench of the MMIO client, runs the operations listed in mmioTests.txt and checks results
`timescale 1ns/1ns

module tbMmioClient
  import mmioPkg::*;
();

  logic        shlClk = 1'b0;
  logic        arstN;
  wbReqT       wbReq;
  wbRspT       wbRsp;
  logic [31:0] timestamp;
  shellStatT   shellStat;
  phyTuneT     phyTune;
  netCfgT      netCfg;
  diagCtrlT    diagCtrl;
  xmemReqT     xmemReq;
  logic [31:0] xmemRdData;

  int          errCount = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          nLines = 0;
  logic [31:0] lfsr;
  // Operations from the data file
  byte         opQ[$];
  logic [31:0] adrQ[$];
  logic [63:0] valQ[$];

  `include "mmioTbTasks.svh"

  always #2 shlClk = ~shlClk;  // 4 ns period

  mmioClient #(
    .xmemPages (16)
  ) mmioClient_inst (
    .shlClk     (shlClk),
    .arstN      (arstN),
    .wbReq      (wbReq),
    .wbRsp      (wbRsp),
    .timestamp  (timestamp),
    .shellStat  (shellStat),
    .phyTune    (phyTune),
    .netCfg     (netCfg),
    .diagCtrl   (diagCtrl),
    .xmemReq    (xmemReq),
    .xmemRdData (xmemRdData)
  );

  // Output field by number, as used in the O lines
  function automatic logic [63:0] fieldValue(input logic [31:0] f);
    case (f)
      0       : return 64'(phyTune.rxEqMode);
      1       : return 64'(phyTune.txSwing);
      2       : return 64'(phyTune.txPreCursor);
      3       : return 64'(phyTune.txPostCursor);
      4       : return 64'(netCfg.macAddr);
      5       : return 64'(netCfg.ipAddr);
      6       : return 64'(netCfg.subNetMask);
      7       : return 64'(netCfg.gatewayAddr);
      8       : return 64'(diagCtrl.pcsLoopbackEn);
      9       : return 64'(diagCtrl.macLoopbackEn);
      10      : return 64'(diagCtrl.macAddrSwapEn);
      11      : return 64'(diagCtrl.memTestCtrl);
      default : return '1;  // Unknown field never matches
    endcase
  endfunction

  // Main sequence --------------------
  initial
  begin
    int          fd;
    string       line;
    byte         op;
    logic [31:0] adr;
    logic [63:0] val;
    logic [7:0]  rd8;
    logic [31:0] rd32;
    int          errBefore;
    arstN     = 1'b0;
    wbReq     = '0;
    xmemReq   = '0;
    timestamp = '0;
    shellStat = '0;
    lfsr      = 32'h80c812a6;
    fd = $fopen("mmioTests.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the data file mmioTests.txt");
      $display("SOME TESTS FAILED");
      $finish;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
        begin
          void'($sscanf(line, "%c %h %h", op, adr, val));
          opQ.push_back(op);
          adrQ.push_back(adr);
          valQ.push_back(val);
        end
      end
      $fclose(fd);
      nLines = opQ.size();
      repeat (3) @(negedge shlClk);  // Reset for 3 cycles
      arstN = 1'b1;
      foreach (opQ[i])
      begin
        errBefore = errCount;
        idleGap();
        case (opQ[i])
          "W" : wbAccess(1'b1, adrQ[i][7:0], valQ[i][7:0], rd8);
          "R" :
          begin
            wbAccess(1'b0, adrQ[i][7:0], 8'h00, rd8);
            checkEq(64'(rd8), valQ[i], $sformatf("host read of %h", adrQ[i][7:0]));
          end
          "S" :
          begin
            shellStat = shellStatT'(adrQ[i][3:0]);
            timestamp = valQ[i][31:0];
            @(negedge shlClk);
          end
          "P" : fabricAccess(1'b1, adrQ[i][8:0], valQ[i][31:0], rd32);
          "Q" :
          begin
            fabricAccess(1'b0, adrQ[i][8:0], 32'h0, rd32);
            checkEq(64'(rd32), valQ[i], $sformatf("fabric read of word %h", adrQ[i][8:0]));
          end
          "O" : checkEq(fieldValue(adrQ[i]), valQ[i], $sformatf("output field %0d", adrQ[i]));
          default :
          begin
            $display("Unknown operation letter %c in test %0d", opQ[i], i);
            errCount++;
          end
        endcase
        if (errCount == errBefore)
          passCount++;
        else
          failCount++;
        $display("test %0d: %c %0h %0h %s", i, opQ[i], adrQ[i], valQ[i],
                 (errCount == errBefore) ? "ok" : "failed");
      end
      $display("tests %0d, passed %0d, failed %0d", nLines, passCount, failCount);
      if (errCount == 0 && nLines > 0)
        $display("ALL TESTS PASSED");
      else
        $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Watchdog, 20 cycles per test line plus reset
  initial
  begin
    wait (nLines > 0);
    #(nLines * 20 * 4 + 3 * 4);
    $display("Watchdog timeout, tests did not finish within %0d cycles", nLines * 20 + 3);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: mmioTests.txt
# op addr data in hex. W/R host write/read, S status (addr) and timestamp (data),
# P/Q fabric word write/read, O output field (addr) check. Data of R, Q and O is expected
R 11 41
R 13 05
R 39 FF
R 3F 01
R 71 AD
O 0 1
O 1 4
O 2 5
O 6 0000FFFF
O 7 01000C0A
O B 0
W 22 02
W 27 A7
W 34 C0
W 74 C5
R 22 02
R 27 A7
R 74 C5
O 4 A70000000002
O 5 000000C0
O 8 1
O 9 0
O A 1
O B 3
W 00 55
R 00 3C
R 01 01
R 02 00
R 04 81
S 0B 9BCA0000
R 05 25
R 06 07
R 07 13
R 10 0B
W 50 AA
R 50 00
W 7F 03
W 84 11
W 85 22
W 86 33
W 87 44
W 88 5A
Q 61 44332211
P 1C2 A1B2C3D4
W 7F 0E
R 88 D4
R 89 C3
R 8A B2
R 8B A1
W 7F 03
R 88 5A

// File: filelist.f
+incdir+.
mmioPkg.sv
xmemDualPortRam.sv
mmioRegFile.sv
mmioBusDecode.sv
mmioClient.sv
tbMmioClient.sv

// File: runSim.sh
#!/bin/sh
# Build and run the MMIO client testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module tbMmioClient -o simMmio
./obj_dir/simMmio > sim.log 2>&1
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0
